// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tanimoto -f tb.f -o tb_tanimoto

out=$(./obj_dir/tb_tanimoto)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '\*\*\* PASSED \*\*\*'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tanimoto_decode.sv
`timescale 1ns/1ps
`include "tanimoto_defs.svh"

module tanimoto_decode (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_vec_valid,
    input  logic [`VEC_W-1:0]        i_vec_data,
    input  logic                     i_vec_last,
    input  logic                     i_almost_full,
    input  logic                     i_rearm,
    output logic                     o_ready,
    output tanimoto_pkg::dec_item_t  o_item
);

    typedef enum logic [1:0] {
        LOAD_REF = 2'd0,
        COMPARE  = 2'd1,
        DRAIN    = 2'd2
    } state_t;

    state_t           state;
    logic [`ID_W-1:0] id_cnt;
    logic             accept;
    logic             ref_done;

    // DRAIN blocks input until the end marker has been read
    assign o_ready  = (state != DRAIN) && !i_almost_full;
    assign accept   = i_vec_valid && o_ready;
    assign ref_done = (id_cnt == `ID_W'(`REF_N - 1));

    // Run state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= LOAD_REF;
        end else begin
            case (state)
                LOAD_REF: begin
                    if (accept && ref_done) begin
                        state <= COMPARE;
                    end
                end
                COMPARE: begin
                    if (accept && i_vec_last) begin
                        state <= DRAIN;
                    end
                end
                default: begin
                    if (i_rearm) begin
                        state <= LOAD_REF;
                    end
                end
            endcase
        end
    end

    // Vector ID is the position of the vector in the run
    always_ff @(posedge clk) begin
        if (!rstn) begin
            id_cnt <= '0;
        end else if (i_rearm) begin
            id_cnt <= '0;
        end else if (accept) begin
            id_cnt <= id_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_item.valid    <= 1'b0;
            o_item.load_ref <= 1'b0;
            o_item.last     <= 1'b0;
        end else begin
            o_item.valid    <= accept;
            o_item.load_ref <= accept && (state == LOAD_REF);
            o_item.last     <= accept && (state == COMPARE) && i_vec_last;
        end
        // Payload only moves on an accepted beat
        if (accept) begin
            o_item.vec <= i_vec_data;
            o_item.id  <= id_cnt;
        end
    end

    // A run must hold at least one compare vector after the references
    a_no_last_in_load_ref: assert property (
        @(posedge clk) disable iff (!rstn)
        (accept && (state == LOAD_REF)) |-> !i_vec_last
    );

endmodule

// File: tanimoto_defs.svh
`ifndef TANIMOTO_DEFS_SVH
`define TANIMOTO_DEFS_SVH

// Vector and input bus width, one vector per beat
`define VEC_W 64
// Popcount of a full vector, 0 to 64
`define CNT_W 7
`define ID_W 8

// Reference lanes and lane index width
`define REF_N 4
`define LANE_W 2

// Lane FIFO depth and the free entries kept for results in flight
`define FIFO_DEPTH 8
`define FIFO_HEADROOM 4

// Threshold table, addressed by CNT(A&B), entries hold CNT(A)+CNT(B)
`define THR_ADDR_W 7
`define THR_W 8

`endif

// File: tanimoto_execute.sv
`timescale 1ns/1ps
`include "tanimoto_defs.svh"

module tanimoto_execute (
    input  logic                     clk,
    input  logic                     rstn,
    input  tanimoto_pkg::dec_item_t  i_item,
    output tanimoto_pkg::exe_item_t  o_item
);

    localparam int HALF_W = `VEC_W / 2;

    // Reference store, lane 0 holds the first reference of the run
    logic [`VEC_W-1:0]  ref_vec [`REF_N];
    logic [`CNT_W-1:0]  ref_cnt [`REF_N];

    // Stage one registers
    logic               s1_valid;
    logic               s1_load_ref;
    logic               s1_last;
    logic [`ID_W-1:0]   s1_id;
    logic [`CNT_W-2:0]  s1_b_lo;
    logic [`CNT_W-2:0]  s1_b_hi;
    logic [`CNT_W-2:0]  s1_ab_lo [`REF_N];
    logic [`CNT_W-2:0]  s1_ab_hi [`REF_N];
    logic [`CNT_W-1:0]  s1_cnt_b;

    // Popcount of half a vector
    function automatic logic [`CNT_W-2:0] half_pop(input logic [HALF_W-1:0] v);
        logic [`CNT_W-2:0] sum;
        sum = '0;
        for (int i = 0; i < HALF_W; i++) begin
            sum = sum + {{(`CNT_W-2){1'b0}}, v[i]};
        end
        return sum;
    endfunction

    // References shift in from the top so that lane index equals reference ID
    always_ff @(posedge clk) begin
        if (i_item.valid && i_item.load_ref) begin
            ref_vec[`REF_N-1] <= i_item.vec;
            for (int l = 0; l < `REF_N - 1; l++) begin
                ref_vec[l] <= ref_vec[l+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid    <= 1'b0;
            s1_load_ref <= 1'b0;
            s1_last     <= 1'b0;
        end else begin
            s1_valid    <= i_item.valid;
            s1_load_ref <= i_item.load_ref;
            s1_last     <= i_item.last;
        end
        s1_id   <= i_item.id;
        s1_b_lo <= half_pop(i_item.vec[HALF_W-1:0]);
        s1_b_hi <= half_pop(i_item.vec[`VEC_W-1:HALF_W]);
        for (int l = 0; l < `REF_N; l++) begin
            s1_ab_lo[l] <= half_pop(i_item.vec[HALF_W-1:0] & ref_vec[l][HALF_W-1:0]);
            s1_ab_hi[l] <= half_pop(i_item.vec[`VEC_W-1:HALF_W] & ref_vec[l][`VEC_W-1:HALF_W]);
        end
    end

    // For a reference item this is its own CNT(A)
    assign s1_cnt_b = {1'b0, s1_b_lo} + {1'b0, s1_b_hi};

    always_ff @(posedge clk) begin
        if (s1_valid && s1_load_ref) begin
            ref_cnt[`REF_N-1] <= s1_cnt_b;
            for (int l = 0; l < `REF_N - 1; l++) begin
                ref_cnt[l] <= ref_cnt[l+1];
            end
        end
    end

    // Stage two sums the halves and attaches the stored reference count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_item.valid    <= 1'b0;
            o_item.load_ref <= 1'b0;
            o_item.last     <= 1'b0;
        end else begin
            o_item.valid    <= s1_valid;
            o_item.load_ref <= s1_load_ref;
            o_item.last     <= s1_last;
        end
        o_item.cmp_id <= s1_id;
        for (int l = 0; l < `REF_N; l++) begin
            o_item.lane[l].cnt_a  <= ref_cnt[l];
            o_item.lane[l].cnt_b  <= s1_cnt_b;
            o_item.lane[l].cnt_ab <= {1'b0, s1_ab_lo[l]} + {1'b0, s1_ab_hi[l]};
        end
    end

    // The last flag from decode only ever rides on a compare item
    a_ref_never_last: assert property (
        @(posedge clk) disable iff (!rstn)
        o_item.valid |-> !(o_item.load_ref && o_item.last)
    );

endmodule

// File: tanimoto_pkg.sv
`include "tanimoto_defs.svh"

package tanimoto_pkg;

    // Accepted vector, tagged as reference or compare item
    typedef struct packed {
        logic                valid;
        logic                load_ref;
        logic                last;
        logic [`VEC_W-1:0]   vec;
        logic [`ID_W-1:0]    id;
    } dec_item_t;

    // Counts of one reference lane against the current compare vector
    typedef struct packed {
        logic [`CNT_W-1:0]   cnt_a;
        logic [`CNT_W-1:0]   cnt_b;
        logic [`CNT_W-1:0]   cnt_ab;
    } lane_cnt_t;

    typedef struct packed {
        logic                          valid;
        logic                          load_ref;
        logic                          last;
        logic [`ID_W-1:0]              cmp_id;
        lane_cnt_t [`REF_N-1:0]        lane;
    } exe_item_t;

    typedef struct packed {
        logic [`ID_W-1:0]    ref_id;
        logic [`ID_W-1:0]    cmp_id;
    } id_pair_t;

    // Threshold table write port
    typedef struct packed {
        logic                    we;
        logic [`THR_ADDR_W-1:0]  addr;
        logic [`THR_W-1:0]       data;
    } thr_wr_t;

endpackage

// File: tanimoto_result.sv
`timescale 1ns/1ps
`include "tanimoto_defs.svh"

module tanimoto_result (
    input  logic                     clk,
    input  logic                     rstn,
    input  tanimoto_pkg::exe_item_t  i_item,
    input  tanimoto_pkg::thr_wr_t    i_thr_wr,
    input  logic                     i_pair_read,
    output logic                     o_almost_full,
    output logic                     o_rearm,
    output logic                     o_pair_valid,
    output tanimoto_pkg::id_pair_t   o_pair,
    output logic                     o_pair_last
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int LVL_W = PTR_W + 1;

    logic [`THR_W-1:0]       thr_mem [2**`THR_ADDR_W];
    logic [`REF_N-1:0]       lane_pass;
    logic [`REF_N-1:0]       lane_wr;
    logic [`REF_N-1:0]       lane_rd;
    logic [`REF_N-1:0]       lane_empty;
    logic [`REF_N-1:0]       lane_full;
    logic [`REF_N-1:0]       lane_afull;
    tanimoto_pkg::id_pair_t  lane_head [`REF_N];
    logic [`LANE_W-1:0]      rr_last;
    logic [`LANE_W-1:0]      rr_sel;
    logic                    any_data;
    logic                    done;
    logic                    end_marker;

    // Largest CNT(A)+CNT(B) that still passes, per CNT(A&B)
    always_ff @(posedge clk) begin
        if (i_thr_wr.we) begin
            thr_mem[i_thr_wr.addr] <= i_thr_wr.data;
        end
    end

    for (genvar l = 0; l < `REF_N; l++) begin : g_lane
        logic [`THR_W-1:0]       sum;
        tanimoto_pkg::id_pair_t  mem [`FIFO_DEPTH];
        logic [PTR_W-1:0]        wr_ptr;
        logic [PTR_W-1:0]        rd_ptr;
        logic [LVL_W-1:0]        level;

        assign sum          = `THR_W'(i_item.lane[l].cnt_a) + `THR_W'(i_item.lane[l].cnt_b);
        assign lane_pass[l] = (sum <= thr_mem[i_item.lane[l].cnt_ab]);
        assign lane_wr[l]   = i_item.valid && !i_item.load_ref && lane_pass[l];
        assign lane_rd[l]   = i_pair_read && any_data && (rr_sel == `LANE_W'(l));

        assign lane_empty[l] = (level == '0);
        assign lane_full[l]  = (level == LVL_W'(`FIFO_DEPTH));
        assign lane_afull[l] = (level > LVL_W'(`FIFO_DEPTH - `FIFO_HEADROOM));
        // Head is visible without a read, FWFT style
        assign lane_head[l]  = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (lane_wr[l]) begin
                mem[wr_ptr] <= '{ref_id: `ID_W'(l), cmp_id: i_item.cmp_id};
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                level  <= '0;
            end else begin
                wr_ptr <= wr_ptr + PTR_W'(lane_wr[l]);
                rd_ptr <= rd_ptr + PTR_W'(lane_rd[l]);
                level  <= level + LVL_W'(lane_wr[l]) - LVL_W'(lane_rd[l]);
            end
        end

        // Headroom must cover every item already past decode
        a_no_write_when_full: assert property (
            @(posedge clk) disable iff (!rstn)
            lane_wr[l] |-> !lane_full[l]
        );
    end

    assign any_data      = ~&lane_empty;
    assign o_almost_full = |lane_afull;

    // Nearest non-empty lane after the one served last wins
    always_comb begin
        logic [`LANE_W-1:0] idx;
        rr_sel = rr_last;
        for (int k = `REF_N; k >= 1; k--) begin
            idx = rr_last + `LANE_W'(k);
            if (!lane_empty[idx]) begin
                rr_sel = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rr_last <= '1;
        end else if (|lane_rd) begin
            rr_last <= rr_sel;
        end
    end

    // Set once the last compare item has written its lanes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
        end else if (o_rearm) begin
            done <= 1'b0;
        end else if (i_item.valid && !i_item.load_ref && i_item.last) begin
            done <= 1'b1;
        end
    end

    assign end_marker   = done && !any_data;
    assign o_pair_valid = any_data || end_marker;
    assign o_pair       = any_data ? lane_head[rr_sel] : '0;
    assign o_pair_last  = end_marker;
    assign o_rearm      = i_pair_read && end_marker;

endmodule

// File: tanimoto_top.sv
`timescale 1ns/1ps
`include "tanimoto_defs.svh"

module tanimoto_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     i_vec_valid,
    input  logic [`VEC_W-1:0]        i_vec_data,
    input  logic                     i_vec_last,
    output logic                     o_ready,
    input  tanimoto_pkg::thr_wr_t    i_thr_wr,
    input  logic                     i_pair_read,
    output logic                     o_pair_valid,
    output tanimoto_pkg::id_pair_t   o_pair,
    output logic                     o_pair_last
);

    tanimoto_pkg::dec_item_t  dec_item;
    tanimoto_pkg::exe_item_t  exe_item;
    logic                     almost_full;
    logic                     rearm;

    // Run control and vector tagging
    tanimoto_decode u_decode (
        .clk           (clk),
        .rstn          (rstn),
        .i_vec_valid   (i_vec_valid),
        .i_vec_data    (i_vec_data),
        .i_vec_last    (i_vec_last),
        .i_almost_full (almost_full),
        .i_rearm       (rearm),
        .o_ready       (o_ready),
        .o_item        (dec_item)
    );

    // Popcounts against all references
    tanimoto_execute u_execute (
        .clk    (clk),
        .rstn   (rstn),
        .i_item (dec_item),
        .o_item (exe_item)
    );

    // Threshold compare, lane queues and output merge
    tanimoto_result u_result (
        .clk           (clk),
        .rstn          (rstn),
        .i_item        (exe_item),
        .i_thr_wr      (i_thr_wr),
        .i_pair_read   (i_pair_read),
        .o_almost_full (almost_full),
        .o_rearm       (rearm),
        .o_pair_valid  (o_pair_valid),
        .o_pair        (o_pair),
        .o_pair_last   (o_pair_last)
    );

endmodule

// File: tb.f
+incdir+.
tanimoto_pkg.sv
tanimoto_decode.sv
tanimoto_execute.sv
tanimoto_result.sv
tanimoto_top.sv
tb_clk_gen.sv
tb_tanimoto.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset is released just after a rising edge, like every other input
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rstn = 1'b1;
    end

endmodule

// File: tb_tanimoto.sv
`timescale 1ns/1ps
`include "tanimoto_defs.svh"

module tb_tanimoto;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_ROWS   = 6;
    localparam int THR_DEPTH  = 2 ** `THR_ADDR_W;
    localparam logic [1:0] MODE_FORMULA = 2'd0;
    localparam logic [1:0] MODE_ZERO    = 2'd1;
    localparam logic [1:0] MODE_MAX     = 2'd2;

    typedef struct packed {
        logic [1:0] mode;
        logic [7:0] n_cmp;
        logic [7:0] hold;
        logic       expect_bp;
    } row_t;

    // Threshold mode, compare vectors, read hold-off, back-pressure expected
    row_t rows [NUM_ROWS] = '{
        '{MODE_FORMULA, 8'd12, 8'd0,  1'b0},
        '{MODE_ZERO,    8'd8,  8'd0,  1'b0},
        '{MODE_MAX,     8'd10, 8'd0,  1'b0},
        '{MODE_MAX,     8'd16, 8'd40, 1'b1},
        '{MODE_FORMULA, 8'd24, 8'd60, 1'b0},
        '{MODE_FORMULA, 8'd6,  8'd0,  1'b0}
    };

    logic                    clk;
    logic                    rstn;
    logic                    vec_valid;
    logic [`VEC_W-1:0]       vec_data;
    logic                    vec_last;
    logic                    ready;
    tanimoto_pkg::thr_wr_t   thr_wr;
    logic                    pair_read;
    logic                    pair_valid;
    tanimoto_pkg::id_pair_t  pair;
    logic                    pair_last;

    logic [15:0]        lfsr_state;
    logic [`VEC_W-1:0]  vecs [260];
    logic [`THR_W-1:0]  thr_model [THR_DEPTH];
    bit                 exp_hit [`REF_N][256];
    bit                 seen [`REF_N][256];
    int                 exp_count;
    int                 rcv_count;
    int                 cur_n;
    int                 err_cnt;
    int                 rows_failed;
    bit                 bp_seen;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) u_clk_gen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    tanimoto_top tanimoto_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .i_vec_valid  (vec_valid),
        .i_vec_data   (vec_data),
        .i_vec_last   (vec_last),
        .o_ready      (ready),
        .i_thr_wr     (thr_wr),
        .i_pair_read  (pair_read),
        .o_pair_valid (pair_valid),
        .o_pair       (pair),
        .o_pair_last  (pair_last)
    );

    // 16-bit Galois LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [`VEC_W-1:0] random_word();
        logic [`VEC_W-1:0] v;
        for (int i = 0; i < `VEC_W; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Sum limit of 3c - c/16 sits near a similarity of 0.5
    function automatic logic [`THR_W-1:0] thr_value(input logic [1:0] mode, input int c);
        int v;
        if (mode == MODE_ZERO) begin
            v = 0;
        end else if (mode == MODE_MAX) begin
            v = 255;
        end else begin
            v = 3 * c - c / 16;
        end
        return (v > 255) ? 8'hFF : v[7:0];
    endfunction

    // Odd compare vectors are noisy copies of a reference so that some pairs pass
    function automatic void make_vectors(input int n);
        logic [`VEC_W-1:0] noise;
        for (int i = 0; i < `REF_N; i++) begin
            vecs[i] = random_word();
        end
        for (int k = 0; k < n; k++) begin
            if (k % 2 == 1) begin
                noise = random_word() & random_word() & random_word();
                vecs[`REF_N + k] = vecs[(k / 2) % `REF_N] ^ noise;
            end else begin
                vecs[`REF_N + k] = random_word();
            end
        end
    endfunction

    function automatic void build_expected(input int n);
        int a;
        int b;
        int c;
        exp_count = 0;
        rcv_count = 0;
        for (int l = 0; l < `REF_N; l++) begin
            for (int id = 0; id < 256; id++) begin
                exp_hit[l][id] = 1'b0;
                seen[l][id]    = 1'b0;
            end
        end
        for (int k = 0; k < n; k++) begin
            for (int l = 0; l < `REF_N; l++) begin
                a = $countones(vecs[l]);
                b = $countones(vecs[`REF_N + k]);
                c = $countones(vecs[l] & vecs[`REF_N + k]);
                if (a + b <= int'(thr_model[c])) begin
                    exp_hit[l][`REF_N + k] = 1'b1;
                    exp_count++;
                end
            end
        end
    endfunction

    function automatic void check_pair(input tanimoto_pkg::id_pair_t p);
        bit in_set;
        in_set = 1'b0;
        if (p.ref_id < `REF_N && p.cmp_id >= `REF_N && p.cmp_id < `REF_N + cur_n) begin
            in_set = exp_hit[p.ref_id][p.cmp_id];
        end
        a_pair_in_set: assert (in_set) else begin
            $display("** Error: o_pair = 0x%h (ref_id 0x%h, cmp_id 0x%h) is not an expected pair",
                     p, p.ref_id, p.cmp_id);
            err_cnt++;
        end
        if (in_set) begin
            a_pair_once: assert (!seen[p.ref_id][p.cmp_id]) else begin
                $display("Pair of reference %0d and compare %0d was delivered twice",
                         p.ref_id, p.cmp_id);
                err_cnt++;
            end
            seen[p.ref_id][p.cmp_id] = 1'b1;
            rcv_count++;
        end
    endfunction

    task automatic load_table(input logic [1:0] mode);
        for (int c = 0; c < THR_DEPTH; c++) begin
            thr_model[c] = thr_value(mode, c);
        end
        @(posedge clk);
        #1;
        for (int c = 0; c < THR_DEPTH; c++) begin
            thr_wr = '{we: 1'b1, addr: c[`THR_ADDR_W-1:0], data: thr_model[c]};
            @(posedge clk);
            #1;
        end
        thr_wr.we = 1'b0;
    endtask

    // Beat is taken on the edge after a low phase that saw o_ready high
    task automatic send_vectors(input int n);
        for (int i = 0; i < `REF_N + n; i++) begin
            vec_valid = 1'b1;
            vec_data  = vecs[i];
            vec_last  = (i == `REF_N + n - 1);
            @(negedge clk);
            while (!ready) begin
                bp_seen = 1'b1;
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        vec_valid = 1'b0;
        vec_last  = 1'b0;
    endtask

    task automatic collect_pairs(input int hold);
        bit finished;
        finished = 1'b0;
        repeat (hold) @(posedge clk);
        #1;
        pair_read = 1'b1;
        while (!finished) begin
            @(negedge clk);
            if (pair_valid && pair_last) begin
                a_marker_zero: assert (pair == '0) else begin
                    $display("** Error: o_pair = 0x%h at the end marker, expected 0x0000", pair);
                    err_cnt++;
                end
                a_all_pairs: assert (rcv_count == exp_count) else begin
                    $display("End marker came after %0d of %0d expected pairs",
                             rcv_count, exp_count);
                    err_cnt++;
                end
                a_ready_low: assert (!ready) else begin
                    $display("o_ready was high while the end marker was shown");
                    err_cnt++;
                end
                finished = 1'b1;
            end else if (pair_valid) begin
                check_pair(pair);
            end
            @(posedge clk);
            #1;
        end
        pair_read = 1'b0;
    endtask

    task automatic run_row(input int r);
        int err_start;
        err_start = err_cnt;
        cur_n     = int'(rows[r].n_cmp);
        bp_seen   = 1'b0;
        load_table(rows[r].mode);
        make_vectors(cur_n);
        build_expected(cur_n);
        fork
            send_vectors(cur_n);
            collect_pairs(int'(rows[r].hold));
        join
        if (rows[r].expect_bp) begin
            a_backpressure: assert (bp_seen) else begin
                $display("o_ready never fell during the read hold-off of row %0d", r);
                err_cnt++;
            end
        end
        if (err_cnt != err_start) begin
            rows_failed++;
        end
        $display("Row %0d: mode %0d, %0d compares, hold-off %0d, %0d of %0d pairs, %s",
                 r, rows[r].mode, cur_n, rows[r].hold, rcv_count, exp_count,
                 (err_cnt == err_start) ? "ok" : "with errors");
    endtask

    initial begin
        vec_valid   = 1'b0;
        vec_data    = '0;
        vec_last    = 1'b0;
        thr_wr      = '0;
        pair_read   = 1'b0;
        err_cnt     = 0;
        rows_failed = 0;
        lfsr_state  = 16'd82;
        wait (rstn === 1'b1);
        @(negedge clk);
        a_reset_state: assert (!pair_valid && !pair_last && ready) else begin
            $display("** Error: after reset o_pair_valid = 0x%h, o_pair_last = 0x%h, o_ready = 0x%h",
                     pair_valid, pair_last, ready);
            err_cnt++;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Rows run: %0d, rows failed: %0d, errors: %0d", NUM_ROWS, rows_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget per row covers table load, vectors, hold-off, every possible pair and slack
    initial begin : watchdog
        int cycles;
        cycles = 16;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycles += THR_DEPTH + `REF_N + 5 * int'(rows[r].n_cmp) + int'(rows[r].hold) + 50;
        end
        #(cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
